// ==== videoPkg.sv ====
// Video side definitions for the display path
// Sync levels, 24-bit colour, the fixed palette and the TMDS control words
package videoPkg;

    // Sync levels as one bundle, all active high
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic vde;                      // Active video
    } syncT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    //------------------------------------------------------------------
    // Fixed 16 colour palette, index 0 black and index 15 white
    //------------------------------------------------------------------
    localparam rgbT palette [0:15] = '{
        24'h000000, 24'h1d2b53, 24'h7e2553, 24'h008751,
        24'hab5236, 24'h5f574f, 24'hc2c3c7, 24'hff004d,
        24'hffa300, 24'hffec27, 24'h00e436, 24'h29adff,
        24'h83769c, 24'hff77a8, 24'hffccaa, 24'hffffff
    };

    // DVI control tokens, index is {c1, c0}
    localparam logic [9:0] ctrlToken [0:3] = '{
        10'b1101010100,                 // 00
        10'b0010101011,                 // 01
        10'b0101010100,                 // 10
        10'b1010101011                  // 11
    };

endpackage

// ==== memPkg.sv ====
// Frame memory definitions
// Request bundle seen by the arbiter and the RAM, plus the host fill command
package memPkg;

    // 12 bits covers a 64 x 64 block frame
    localparam int memAddrWidth = 12;

    typedef logic [3:0] idxT;           // Palette index

    //------------------------------------------------------------------
    // One memory access, read or write
    //------------------------------------------------------------------
    typedef struct packed {
        logic                    req;
        logic                    we;    // 1 write, 0 read
        logic [memAddrWidth-1:0] addr;
        idxT                     wdata;
    } memReqT;

    // Host command, fills count words from startAddr with one index
    typedef struct packed {
        logic [memAddrWidth-1:0] startAddr;
        logic [memAddrWidth-1:0] count;
        idxT                     index;
    } fillCmdT;

endpackage

// ==== videoTiming.sv ====
// Display timing generator
// Free running line and frame counters, registered sync levels and a
// frame start pulse on the first pixel of line 0
`timescale 1ns/1ps

module videoTiming #(
    parameter int hDisplay = 640,
    parameter int hFront   = 16,
    parameter int hSync    = 96,
    parameter int hBack    = 48,
    parameter int vDisplay = 480,
    parameter int vFront   = 10,
    parameter int vSync    = 2,
    parameter int vBack    = 33
)(
    input  logic           pixelClk,
    input  logic           rstN,
    output videoPkg::syncT sync,
    output logic [11:0]    hPos,
    output logic [11:0]    vPos,
    output logic           frameStart
);

    localparam int hTotal     = hDisplay + hFront + hSync + hBack;
    localparam int vTotal     = vDisplay + vFront + vSync + vBack;
    localparam int hSyncStart = hDisplay + hFront;     // Pulse after front porch
    localparam int vSyncStart = vDisplay + vFront;

    logic [11:0] hNext;
    logic [11:0] vNext;

    //------------------------------------------------------------------
    // Next position, wraps at line end and at frame end
    //------------------------------------------------------------------
    always_comb
    begin
        hNext = hPos + 12'd1;
        vNext = vPos;
        if (hPos == 12'(hTotal - 1))
        begin
            hNext = '0;
            if (vPos == 12'(vTotal - 1))
                vNext = '0;
            else
                vNext = vPos + 12'd1;   // Next line
        end
    end

    // Sync decoded from the next position so it lines up with hPos/vPos
    always_ff @(posedge pixelClk or negedge rstN)
    begin
        if (!rstN)
        begin
            hPos       <= '0;
            vPos       <= '0;
            sync       <= '0;
            frameStart <= 1'b0;
        end
        else
        begin
            hPos       <= hNext;
            vPos       <= vNext;
            sync.hsync <= (hNext >= 12'(hSyncStart)) && (hNext < 12'(hSyncStart + hSync));
            sync.vsync <= (vNext >= 12'(vSyncStart)) && (vNext < 12'(vSyncStart + vSync));
            sync.vde   <= (hNext < 12'(hDisplay)) && (vNext < 12'(vDisplay));
            frameStart <= (hNext == '0) && (vNext == '0);      // One cycle
        end
    end

endmodule

// ==== memArbiter.sv ====
// Frame memory arbiter
// Fixed priority, display fetch first so scan-out never stalls.
// The fill engine only moves on when fillGrant is high
`timescale 1ns/1ps

module memArbiter (
    input  memPkg::memReqT displayReq,
    input  memPkg::memReqT fillReq,
    output memPkg::memReqT memReq,
    output logic           fillGrant
);

    //------------------------------------------------------------------
    // Grant, purely combinational
    //------------------------------------------------------------------
    // Fill wins only when the display is idle (blanking)
    assign fillGrant = fillReq.req && !displayReq.req;

    // Port mux
    always_comb
    begin
        if (displayReq.req)
            memReq = displayReq;        // Scan-out read
        else
            memReq = fillReq;           // Fill write, or idle when req low
    end

endmodule

// ==== frameMemory.sv ====
// Frame memory of palette indices, one entry per screen block
// Single port block RAM, read data registered on every request
`timescale 1ns/1ps

module frameMemory #(
    parameter int memDepth = 1200
)(
    input  logic           pixelClk,
    input  memPkg::memReqT memReq,
    output memPkg::idxT    rdata
);

    localparam int addrBits = $clog2(memDepth);

    memPkg::idxT              mem [memDepth];
    logic [addrBits-1:0]      addrLow;

    // Low address bits, power of two depths alias the full address space
    assign addrLow = memReq.addr[addrBits-1:0];

    // Black screen at start
    initial
    begin
        for (int i = 0; i < memDepth; i++)
            mem[i] = '0;
    end

    always_ff @(posedge pixelClk)
    begin
        if (memReq.req)
        begin
            if (memReq.we && (int'(addrLow) < memDepth))
                mem[addrLow] <= memReq.wdata;
            rdata <= mem[addrLow];      // Read before write
        end
    end

endmodule

// ==== fillEngine.sv ====
// Fill engine, writes a run of one palette index into the frame memory
// Host pulses cmdValid with cmd, busy holds until the last word lands.
// Commands seen while busy are dropped
`timescale 1ns/1ps

module fillEngine (
    input  logic            pixelClk,
    input  logic            rstN,
    input  logic            cmdValid,
    input  memPkg::fillCmdT cmd,
    input  logic            fillGrant,
    output memPkg::memReqT  fillReq,
    output logic            busy
);

    logic [memPkg::memAddrWidth-1:0] addr;
    logic [memPkg::memAddrWidth-1:0] remaining;    // Words still to write
    memPkg::idxT                     index;

    //------------------------------------------------------------------
    // Write request, held until granted
    //------------------------------------------------------------------
    always_comb
    begin
        fillReq.req   = busy && (remaining != '0);
        fillReq.we    = 1'b1;                       // Write only
        fillReq.addr  = addr;
        fillReq.wdata = index;
    end

    // Busy flag
    always_ff @(posedge pixelClk or negedge rstN)
    begin
        if (!rstN)
            busy <= 1'b0;
        else if (!busy)
            busy <= cmdValid;                       // Accept on strobe
        else if (remaining == '0)
            busy <= 1'b0;                           // Zero count command
        else if (fillGrant && (remaining == 1))
            busy <= 1'b0;                           // Last word written
    end

    // Address and count, stall while the display owns the memory
    always_ff @(posedge pixelClk)
    begin
        if (!busy && cmdValid)
        begin
            addr      <= cmd.startAddr;
            remaining <= cmd.count;
            index     <= cmd.index;
        end
        else if (fillGrant)
        begin
            addr      <= addr + 1'b1;               // Wraps at the address top
            remaining <= remaining - 1'b1;
        end
    end

endmodule

// ==== pixelFetch.sv ====
// Display fetch, screen position to block address, palette lookup.
// Two cycle pipeline, memory read then palette register, sync delayed
// to match
`timescale 1ns/1ps

module pixelFetch #(
    parameter int hDisplay   = 640,
    parameter int scaleShift = 4
)(
    input  logic           pixelClk,
    input  logic           rstN,
    input  videoPkg::syncT syncIn,
    input  logic [11:0]    hPos,
    input  logic [11:0]    vPos,
    output memPkg::memReqT displayReq,
    input  memPkg::idxT    rdata,
    output videoPkg::rgbT  pixel,
    output videoPkg::syncT sync
);

    localparam int blockWidth = hDisplay >> scaleShift;    // Blocks per row

    logic [11:0]    blockRow;
    logic [11:0]    blockCol;
    logic [11:0]    rowBase;
    videoPkg::syncT syncD1;             // Aligned with rdata

    //------------------------------------------------------------------
    // Address, row * width + column
    //------------------------------------------------------------------
    assign blockRow = vPos >> scaleShift;
    assign blockCol = hPos >> scaleShift;
    assign rowBase  = 12'(blockRow * blockWidth);

    // Read only during active video
    always_comb
    begin
        displayReq.req   = syncIn.vde;
        displayReq.we    = 1'b0;
        displayReq.addr  = rowBase + blockCol;
        displayReq.wdata = '0;
    end

    //------------------------------------------------------------------
    // Sync delay, two stages
    //------------------------------------------------------------------
    always_ff @(posedge pixelClk or negedge rstN)
    begin
        if (!rstN)
        begin
            syncD1 <= '0;
            sync   <= '0;
        end
        else
        begin
            syncD1 <= syncIn;
            sync   <= syncD1;
        end
    end

    // Palette register, black in blanking
    always_ff @(posedge pixelClk)
    begin
        if (syncD1.vde)
            pixel <= videoPkg::palette[rdata];
        else
            pixel <= '0;
    end

endmodule

// ==== tmdsEncoder.sv ====
// One TMDS channel encoder after DVI 1.0
// Transition minimising, DC balance through a running disparity count,
// control tokens while de is low. One registered cycle
`timescale 1ns/1ps

module tmdsEncoder (
    input  logic       pixelClk,
    input  logic       rstN,
    input  logic [7:0] data,
    input  logic [1:0] ctrl,
    input  logic       de,
    output logic [9:0] tmds
);

    logic [3:0]        dataOnes;
    logic              useXnor;
    logic [8:0]        qm;              // Transition minimised word
    logic [3:0]        qmOnes;
    logic signed [5:0] qmBal;           // Ones minus zeros in qm[7:0]
    logic signed [5:0] dispCnt;         // Running disparity

    //------------------------------------------------------------------
    // Stage 1 of the algorithm, XOR or XNOR chain
    //------------------------------------------------------------------
    always_comb
    begin
        dataOnes = '0;
        for (int i = 0; i < 8; i++)
            dataOnes = dataOnes + 4'(data[i]);
        useXnor = (dataOnes > 4'd4) || ((dataOnes == 4'd4) && !data[0]);
        qm[0] = data[0];
        for (int i = 1; i < 8; i++)
        begin
            if (useXnor)
                qm[i] = ~(qm[i-1] ^ data[i]);
            else
                qm[i] = qm[i-1] ^ data[i];
        end
        qm[8] = !useXnor;               // 1 marks XOR
        qmOnes = '0;
        for (int i = 0; i < 8; i++)
            qmOnes = qmOnes + 4'(qm[i]);
        qmBal = $signed({1'b0, qmOnes, 1'b0}) - 6'sd8;     // 2*ones - 8
    end

    //------------------------------------------------------------------
    // Stage 2, conditional inversion and disparity update
    //------------------------------------------------------------------
    always_ff @(posedge pixelClk or negedge rstN)
    begin
        if (!rstN)
        begin
            tmds    <= videoPkg::ctrlToken[0];
            dispCnt <= '0;
        end
        else if (!de)
        begin
            tmds    <= videoPkg::ctrlToken[ctrl];          // Blanking
            dispCnt <= '0;
        end
        else if ((dispCnt == 0) || (qmBal == 0))
        begin
            tmds    <= {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            dispCnt <= qm[8] ? dispCnt + qmBal : dispCnt - qmBal;
        end
        else if (((dispCnt > 0) && (qmBal > 0)) || ((dispCnt < 0) && (qmBal < 0)))
        begin
            tmds    <= {1'b1, qm[8], ~qm[7:0]};            // Invert to pull back
            dispCnt <= dispCnt + (qm[8] ? 6'sd2 : 6'sd0) - qmBal;
        end
        else
        begin
            tmds    <= {1'b0, qm[8], qm[7:0]};
            dispCnt <= dispCnt - (qm[8] ? 6'sd0 : 6'sd2) + qmBal;
        end
    end

endmodule

// ==== displayTop.sv ====
// Video path top level
// Timing, shared frame memory with fill engine, fetch and three TMDS
// channels. Words leave in parallel, one per pixelClk
`timescale 1ns/1ps

module displayTop #(
    parameter int hDisplay   = 640,
    parameter int hFront     = 16,
    parameter int hSync      = 96,
    parameter int hBack      = 48,
    parameter int vDisplay   = 480,
    parameter int vFront     = 10,
    parameter int vSync      = 2,
    parameter int vBack      = 33,
    parameter int scaleShift = 4
)(
    input  logic            pixelClk,
    input  logic            rstN,
    input  logic            cmdValid,
    input  memPkg::fillCmdT cmd,
    output logic            busy,
    output logic [9:0]      tmdsBlue,
    output logic [9:0]      tmdsGreen,
    output logic [9:0]      tmdsRed
);

    // One entry per block
    localparam int memDepth = (hDisplay >> scaleShift) * (vDisplay >> scaleShift);

    videoPkg::syncT timingSync;         // At counter position
    videoPkg::syncT pixelSync;          // Two cycles later, with pixel
    videoPkg::rgbT  pixel;
    logic [11:0]    hPos;
    logic [11:0]    vPos;
    logic           frameStart;
    memPkg::memReqT displayReq;
    memPkg::memReqT fillReq;
    memPkg::memReqT memReq;
    logic           fillGrant;
    memPkg::idxT    rdata;

    //------------------------------------------------------------------
    // Timing and memory side
    //------------------------------------------------------------------
    videoTiming #(
        .hDisplay (hDisplay), .hFront (hFront), .hSync (hSync), .hBack (hBack),
        .vDisplay (vDisplay), .vFront (vFront), .vSync (vSync), .vBack (vBack)
    ) timing (
        .pixelClk   (pixelClk),
        .rstN       (rstN),
        .sync       (timingSync),
        .hPos       (hPos),
        .vPos       (vPos),
        .frameStart (frameStart)
    );

    memArbiter arbiter (
        .displayReq (displayReq),
        .fillReq    (fillReq),
        .memReq     (memReq),
        .fillGrant  (fillGrant)
    );

    frameMemory #(.memDepth (memDepth)) frameMem (
        .pixelClk (pixelClk),
        .memReq   (memReq),
        .rdata    (rdata)
    );

    fillEngine filler (
        .pixelClk  (pixelClk),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .fillGrant (fillGrant),
        .fillReq   (fillReq),
        .busy      (busy)
    );

    pixelFetch #(.hDisplay (hDisplay), .scaleShift (scaleShift)) fetch (
        .pixelClk   (pixelClk),
        .rstN       (rstN),
        .syncIn     (timingSync),
        .hPos       (hPos),
        .vPos       (vPos),
        .displayReq (displayReq),
        .rdata      (rdata),
        .pixel      (pixel),
        .sync       (pixelSync)
    );

    //------------------------------------------------------------------
    // TMDS channels, sync rides on blue only
    //------------------------------------------------------------------
    tmdsEncoder blueEnc (
        .pixelClk (pixelClk), .rstN (rstN), .data (pixel.blue),
        .ctrl ({pixelSync.vsync, pixelSync.hsync}), .de (pixelSync.vde), .tmds (tmdsBlue)
    );

    tmdsEncoder greenEnc (
        .pixelClk (pixelClk), .rstN (rstN), .data (pixel.green),
        .ctrl (2'b00), .de (pixelSync.vde), .tmds (tmdsGreen)
    );

    tmdsEncoder redEnc (
        .pixelClk (pixelClk), .rstN (rstN), .data (pixel.red),
        .ctrl (2'b00), .de (pixelSync.vde), .tmds (tmdsRed)
    );

endmodule

// ==== tbClock.sv ====
// Testbench clock source, free running from time zero
// Period set by parameter, 4 ns by default
`timescale 1ns/1ps

module tbClock #(
    parameter real period = 4.0         // ns
)(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2.0) clk = ~clk;
    end

endmodule

// ==== displayTb.sv ====
// Testbench for the video path in a small 32 x 16 mode
// Random fill commands drive it and the TMDS words are decoded back to sync
// codes and pixels
`timescale 1ns/1ps

module displayTb;

    localparam int hTotal = 40;                     // 32 + 2 + 4 + 2
    localparam int vTotal = 20;                     // 16 + 1 + 2 + 1
    localparam logic [9:0] tokens [4] = '{10'h354, 10'h0ab, 10'h154, 10'h2ab};

    logic            clk;
    logic            rstN;
    logic            cmdValid;
    memPkg::fillCmdT cmd;
    logic            busy;
    logic [9:0]      tmdsBlue;
    logic [9:0]      tmdsGreen;
    logic [9:0]      tmdsRed;
    logic [9:0]      word [3];                      // Blue, green, red
    logic [2:0]      code [3];                      // {control, c1, c0}
    logic [3:0]      refImage [32];                 // Expected block indices
    logic [3:0]      prevImage [32];                // Image before the fill in flight
    logic [23:0]     rgb;
    int              disp [3];                      // Ones minus zeros per channel
    int              checks;
    int              errors;
    int              wordCnt;
    int              frameCount;
    int              hRun;
    int              vRun;
    int              row;
    int              col;
    int              lastHRise = -1;
    int              lastVRise = -1;
    bit              hNow;
    bit              vNow;
    bit              prevH;
    bit              prevV;
    bit              lastData;
    bit              rowKnown;                      // Set at the first vsync

    tbClock clockGen (.clk (clk));

    displayTop #(
        .hDisplay (32), .hFront (2), .hSync (4), .hBack (2),
        .vDisplay (16), .vFront (1), .vSync (2), .vBack (1), .scaleShift (2)
    ) UUT (
        .pixelClk (clk), .rstN (rstN), .cmdValid (cmdValid), .cmd (cmd), .busy (busy),
        .tmdsBlue (tmdsBlue), .tmdsGreen (tmdsGreen), .tmdsRed (tmdsRed)
    );

    task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // Either image is legal while a fill is still landing
    task automatic compareEither(string name, logic [31:0] got, logic [31:0] expNew,
                                 logic [31:0] expOld);
        checks++;
        assert ((got == expNew) || (got == expOld))
        else
        begin
            errors++;
            $display("Error: %s = %h, expected %h or %h", name, got, expNew, expOld);
        end
    endtask

    task automatic requireTrue(bit cond, string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("Check failed: %s", what);
        end
    endtask

    task automatic stopOnTimeout(string what);
        $display("Timeout: %s", what);
        $display("Checks: %0d, errors: %0d, timeouts: 1", checks, errors);
        $display("** FAIL **");
        $finish;
    endtask

    //------------------------------------------------------------------
    // TMDS decoder model
    //------------------------------------------------------------------
    function automatic logic [2:0] ctrlCode(logic [9:0] w);
        for (int i = 0; i < 4; i++)
            if (w == tokens[i])
                return {1'b1, 2'(i)};
        return 3'b000;                              // Data word
    endfunction

    function automatic logic [7:0] dataByte(logic [9:0] w);
        logic [7:0] q;
        logic [7:0] d;
        q    = w[9] ? ~w[7:0] : w[7:0];             // Undo inversion
        d[0] = q[0];
        for (int i = 1; i < 8; i++)
            d[i] = w[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        return d;
    endfunction

    function automatic memPkg::fillCmdT randomCmd(int minCount);
        memPkg::fillCmdT c;
        c.startAddr = 12'($urandom % 32);
        c.count     = 12'(minCount + $urandom % (33 - minCount));
        c.index     = 4'($urandom);
        return c;
    endfunction

    // Output monitor samples at the falling edge where words are stable
    always @(negedge clk)
    begin
        word[0] = tmdsBlue;
        word[1] = tmdsGreen;
        word[2] = tmdsRed;
        for (int c = 0; c < 3; c++)
            code[c] = ctrlCode(word[c]);
        if (!rstN)
        begin
            compareValue("busy", busy, 0);
            for (int c = 0; c < 3; c++)
                compareValue("tmds word in reset", word[c], tokens[0]);
        end
        else
        begin
            wordCnt++;
            for (int c = 0; c < 3; c++)
            begin
                disp[c] = code[c][2] ? 0 : disp[c] + 2 * $countones(word[c]) - 10;
                requireTrue(disp[c] >= -10 && disp[c] <= 10, "DC balance out of range");
            end
            if (code[1][2])
                compareValue("tmdsGreen code", code[1][1:0], 0);
            if (code[2][2])
                compareValue("tmdsRed code", code[2][1:0], 0);
            hNow = code[0][2] & code[0][0];
            vNow = code[0][2] & code[0][1];
            if (hNow && !prevH && lastHRise >= 0)
                compareValue("line period", wordCnt - lastHRise, hTotal);
            if (hNow && !prevH)
                lastHRise = wordCnt;
            if (prevH && !hNow)
                compareValue("hsync run", hRun, 4);
            if (prevV && !vNow)
                compareValue("vsync run", vRun, 2 * hTotal);
            hRun = hNow ? hRun + 1 : 0;
            vRun = vNow ? vRun + 1 : 0;
            if (vNow && !prevV)                     // Vsync rise
            begin
                if (lastVRise >= 0)
                    compareValue("frame period", wordCnt - lastVRise, hTotal * vTotal);
                lastVRise = wordCnt;
            end
            if (UUT.frameStart)                     // Counters at line 0, pixel 0
            begin
                frameCount++;
                if (!busy)
                    prevImage = refImage;           // Fill done so only the new image counts
            end
            if (!code[0][2] && rowKnown)
            begin
                requireTrue(row < 16 && col < 32, "active pixel outside the display area");
                rgb = {dataByte(word[2]), dataByte(word[1]), dataByte(word[0])};
                compareEither("pixel", rgb,
                              videoPkg::palette[refImage[(row / 4) * 8 + col / 4]],
                              videoPkg::palette[prevImage[(row / 4) * 8 + col / 4]]);
            end
            if (!code[0][2])
                col++;
            else if (lastData)
            begin
                row++;                              // Line ended
                col = 0;
            end
            if (vNow)
            begin
                row      = 0;
                col      = 0;
                rowKnown = 1'b1;
            end
            lastData = !code[0][2];
            prevH    = hNow;
            prevV    = vNow;
        end
    end

    //------------------------------------------------------------------
    // Host side stimulus and waits
    //------------------------------------------------------------------
    task automatic issueFill(memPkg::fillCmdT c, bit accepted);
        @(posedge clk);
        cmdValid <= 1'b1;
        cmd      <= c;
        @(posedge clk);
        cmdValid <= 1'b0;
        if (accepted)
            for (int i = 0; i < c.count; i++)
                refImage[(c.startAddr + i) % 32] = c.index;     // Wraps at the top
        @(negedge clk);
        requireTrue(busy, "busy not high after a command");
    endtask

    task automatic waitFrames(int n);
        int target;
        int t;
        target = frameCount + n;
        t      = 0;
        while (frameCount < target && t < (n + 1) * hTotal * vTotal)
        begin
            @(posedge clk);
            t++;
        end
        if (frameCount < target)
            stopOnTimeout("no frame start seen");
    endtask

    task automatic waitBusyLow();
        int t;
        t = 0;
        while (busy && t < 4000)
        begin
            @(negedge clk);
            t++;
        end
        if (busy)
            stopOnTimeout("fill engine stayed busy");
    endtask

    task automatic waitOutput(bit wantData);
        int t;
        t = 0;
        while (!(rowKnown && lastData == wantData && (!wantData || col == 6)) && t < 2000)
        begin
            @(posedge clk);
            t++;
        end
        if (t >= 2000)
            stopOnTimeout("expected video phase not reached");
    endtask

    initial
    begin
        rstN     = 1'b0;
        cmdValid = 1'b0;
        cmd      = '0;
        for (int i = 0; i < 32; i++)
        begin
            refImage[i]  = '0;                      // Memory starts black
            prevImage[i] = '0;
        end
        void'($urandom(32'h45c4_bc54));
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        compareValue("busy", busy, 0);              // Just after release
        compareValue("tmdsBlue", tmdsBlue, tokens[0]);
        compareValue("tmdsGreen", tmdsGreen, tokens[0]);
        compareValue("tmdsRed", tmdsRed, tokens[0]);
        waitFrames(2);
        repeat (6)
        begin
            issueFill(randomCmd(0), 1'b1);
            waitBusyLow();
            waitFrames(2);
        end
        waitOutput(1'b1);                           // Middle of an active line
        issueFill(randomCmd(16), 1'b1);
        waitOutput(1'b0);
        @(negedge clk);
        requireTrue(busy, "fill finished while the display held the memory");
        waitBusyLow();
        waitFrames(2);
        issueFill(randomCmd(32), 1'b1);             // Long fill
        issueFill(randomCmd(1), 1'b0);              // Dropped while busy
        waitBusyLow();
        waitFrames(2);
        $display("Checks: %0d, errors: %0d, timeouts: 0", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sources.f ====
videoPkg.sv
memPkg.sv
videoTiming.sv
memArbiter.sv
frameMemory.sv
fillEngine.sv
pixelFetch.sv
tmdsEncoder.sv
displayTop.sv
tbClock.sv
displayTb.sv
